//--- project.f
source/systolic_pkg.sv
source/weight_bank.sv
source/input_skew.sv
source/systolic_pe.sv
source/pe_array.sv
source/output_deskew.sv
source/result_stage.sv
source/systolic_top.sv
tests/result_checker.sv
tests/systolic_tb.sv

//--- tests/systolic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_tb;

    localparam int NUM_PHASES     = 6;
    localparam int ROWS_PER_PHASE = 40;
    localparam int CFG_CYCLES     = systolic_pkg::WEIGHT_CNT + 1;
    localparam int CLK_PERIOD     = 8;
    localparam int N              = systolic_pkg::ARRAY_N;
    localparam int PW             = systolic_pkg::PIXEL_W;
    localparam longint WATCHDOG_NS = 2 * NUM_PHASES * (CFG_CYCLES + ROWS_PER_PHASE * 4
                                     + systolic_pkg::PIPE_LATENCY * 4) * CLK_PERIOD;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           en;
    logic                           row_valid;
    logic [systolic_pkg::ROW_W-1:0] row_pixels;
    logic                           cfg_wr;
    systolic_pkg::cfg_reg_t         cfg_sel;
    logic [3:0]                     cfg_addr;
    logic [15:0]                    cfg_data;
    logic                           result_valid;
    logic [systolic_pkg::ROW_W-1:0] result_pixels;
    int                             mismatch_count;
    int                             error_count;
    int                             pending;

    always #(CLK_PERIOD / 2) clk = ~clk;

    systolic_top systolic_top_i (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .row_valid     (row_valid),
        .row_pixels    (row_pixels),
        .cfg_wr        (cfg_wr),
        .cfg_sel       (cfg_sel),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .result_valid  (result_valid),
        .result_pixels (result_pixels)
    );

    result_checker result_checker_i (
        .clk            (clk),
        .reset          (reset),
        .en             (en),
        .row_valid      (row_valid),
        .row_pixels     (row_pixels),
        .cfg_wr         (cfg_wr),
        .cfg_sel        (cfg_sel),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .result_valid   (result_valid),
        .result_pixels  (result_pixels),
        .mismatch_count (mismatch_count),
        .error_count    (error_count),
        .pending        (pending)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // mode 0 small, mode 1 extremes, mode 2 full range
    function automatic logic [15:0] random_value(input int mode);
        logic [15:0] value;
        if (mode == 0) begin
            value = 16'($urandom_range(127, 0)) - 16'd64;
        end else if (mode == 1) begin
            case ($urandom_range(3, 0))
                0: value = 16'h7fff;
                1: value = 16'h8000;
                2: value = 16'h8001;
                default: value = 16'($urandom);
            endcase
        end else begin
            value = 16'($urandom);
        end
        return value;
    endfunction

    task automatic write_config(input systolic_pkg::cfg_reg_t sel, input logic [3:0] addr,
                                input logic [15:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_sel   <= sel;
        cfg_addr  <= addr;
        cfg_data  <= data;
        en        <= 1'b0;
        row_valid <= 1'b0;
    endtask

    // hold en high until every accepted row has come back
    task automatic drain;
        @(posedge clk);
        cfg_wr    <= 1'b0;
        en        <= 1'b1;
        row_valid <= 1'b0;
        @(posedge clk);
        while (pending != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic run_phase(input int phase);
        int                             mode;
        int                             shift;
        int                             accepted;
        logic                           go;
        logic                           valid;
        logic [systolic_pkg::ROW_W-1:0] row;
        mode = phase % 3;
        if (mode == 0 || phase == 1) begin
            shift = 0;
        end else if (phase == NUM_PHASES - 2) begin
            shift = 31;
        end else begin
            shift = $urandom_range(31, 0);
        end
        for (int k = 0; k < systolic_pkg::WEIGHT_CNT; k++) begin
            write_config(systolic_pkg::REG_WEIGHT, 4'(k), random_value(mode));
        end
        write_config(systolic_pkg::REG_SHIFT, 4'd0, 16'(shift));
        accepted = 0;
        while (accepted < ROWS_PER_PHASE) begin
            go = ($urandom_range(3, 0) != 0);
            valid = ($urandom_range(2, 0) != 0);
            for (int i = 0; i < N; i++) begin
                row[i*PW +: PW] = random_value(mode);
            end
            @(posedge clk);
            cfg_wr     <= 1'b0;
            en         <= go;
            row_valid  <= valid;
            row_pixels <= row;
            if (go && valid) begin
                accepted++;
            end
        end
        drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        en         = 1'b0;
        row_valid  = 1'b0;
        row_pixels = '0;
        cfg_wr     = 1'b0;
        cfg_sel    = systolic_pkg::REG_WEIGHT;
        cfg_addr   = '0;
        cfg_data   = '0;
        void'($urandom(91778));
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            run_phase(p);
        end
        repeat (4) @(posedge clk);
        $display("mismatches %0d, other errors %0d", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, results did not drain", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/result_checker.sv
`timescale 1ns/1ps
`default_nettype none

module result_checker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            en,
    input  logic                            row_valid,
    input  logic [systolic_pkg::ROW_W-1:0]  row_pixels,
    input  logic                            cfg_wr,
    input  systolic_pkg::cfg_reg_t          cfg_sel,
    input  logic [3:0]                      cfg_addr,
    input  logic [15:0]                     cfg_data,
    input  logic                            result_valid,
    input  logic [systolic_pkg::ROW_W-1:0]  result_pixels,
    output int                              mismatch_count,
    output int                              error_count,
    output int                              pending
);

    localparam int N  = systolic_pkg::ARRAY_N;
    localparam int PW = systolic_pkg::PIXEL_W;

    logic signed [systolic_pkg::WEIGHT_W-1:0] model_w [systolic_pkg::WEIGHT_CNT];
    int                                       model_shift;
    logic [systolic_pkg::ROW_W-1:0]           expect_q [$];
    int                                       stamp_q [$];
    int                                       en_edges;
    logic                                     en_prev;
    logic [systolic_pkg::ROW_W-1:0]           held_pixels;
    int                                       mismatches = 0;
    int                                       errors = 0;

    // y[j] = sum of x[i]*w[i][j], then shift and clamp
    function automatic logic [systolic_pkg::ROW_W-1:0] expected_row(
        input logic [systolic_pkg::ROW_W-1:0] pixels
    );
        longint                         sum;
        logic [systolic_pkg::ROW_W-1:0] row;
        row = '0;
        for (int j = 0; j < N; j++) begin
            sum = 0;
            for (int i = 0; i < N; i++) begin
                sum += longint'($signed(pixels[i*PW +: PW])) * longint'(model_w[i*N+j]);
            end
            sum = sum >>> model_shift;
            if (sum > 32767) begin
                sum = 32767;
            end else if (sum < -32768) begin
                sum = -32768;
            end
            row[j*PW +: PW] = sum[PW-1:0];
        end
        return row;
    endfunction

    always @(posedge clk) begin
        logic [systolic_pkg::ROW_W-1:0] exp_row;
        int                             exp_stamp;
        if (reset) begin
            for (int k = 0; k < systolic_pkg::WEIGHT_CNT; k++) begin
                model_w[k] = '0;
            end
            model_shift = 0;
            expect_q.delete();
            stamp_q.delete();
            en_edges = 0;
            en_prev = 1'b0;
            held_pixels = '0;
        end else begin
            // result_valid here was set by the previous edge
            if (result_valid) begin
                if (!en_prev) begin
                    errors++;
                    $display("result_valid pulsed after an edge with en low");
                end
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("result_valid pulsed with no row in flight");
                end else begin
                    exp_row = expect_q.pop_front();
                    exp_stamp = stamp_q.pop_front();
                    // acceptance edge counts as the first enabled cycle
                    if (en_edges != exp_stamp + systolic_pkg::PIPE_LATENCY - 1) begin
                        errors++;
                        $display("result arrived at enabled edge %0d instead of edge %0d",
                                 en_edges, exp_stamp + systolic_pkg::PIPE_LATENCY - 1);
                    end
                    for (int j = 0; j < N; j++) begin
                        if (result_pixels[j*PW +: PW] !== exp_row[j*PW +: PW]) begin
                            mismatches++;
                            $display("MISMATCH result_pixels lane %0d expected %h actual %h",
                                     j, exp_row[j*PW +: PW], result_pixels[j*PW +: PW]);
                        end
                    end
                end
                held_pixels = result_pixels;
            end else if (result_pixels !== held_pixels) begin
                mismatches++;
                $display("MISMATCH result_pixels held value expected %h actual %h",
                         held_pixels, result_pixels);
            end

            if (cfg_wr) begin
                if (cfg_sel == systolic_pkg::REG_WEIGHT) begin
                    model_w[cfg_addr] = cfg_data;
                end else begin
                    model_shift = int'(cfg_data[systolic_pkg::SHIFT_W-1:0]);
                end
            end

            if (en) begin
                en_edges++;
                if (row_valid) begin
                    expect_q.push_back(expected_row(row_pixels));
                    stamp_q.push_back(en_edges);
                end
            end
            en_prev = en;
        end
        mismatch_count <= mismatches;
        error_count    <= errors;
        pending        <= expect_q.size();
    end

endmodule

`default_nettype wire

//--- source/systolic_top.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic                                row_valid,
    input  logic [systolic_pkg::ROW_W-1:0]      row_pixels,
    input  logic                                cfg_wr,
    input  systolic_pkg::cfg_reg_t              cfg_sel,
    input  logic [3:0]                          cfg_addr,
    input  logic [15:0]                         cfg_data,
    output logic                                result_valid,
    output logic [systolic_pkg::ROW_W-1:0]      result_pixels
);

    logic [systolic_pkg::WEIGHTS_W-1:0] weights;
    logic [systolic_pkg::SHIFT_W-1:0]   shift_amount;
    logic [systolic_pkg::ROW_W-1:0]     skewed_pixels;
    logic [systolic_pkg::SUMS_W-1:0]    column_sums;
    logic [systolic_pkg::SUMS_W-1:0]    aligned_sums;

    weight_bank weight_bank_i (
        .clk          (clk),
        .reset        (reset),
        .cfg_wr       (cfg_wr),
        .cfg_sel      (cfg_sel),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .weights      (weights),
        .shift_amount (shift_amount)
    );

    input_skew input_skew_i (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .row_pixels    (row_pixels),
        .skewed_pixels (skewed_pixels)
    );

    pe_array pe_array_i (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .skewed_pixels (skewed_pixels),
        .weights       (weights),
        .column_sums   (column_sums)
    );

    output_deskew output_deskew_i (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .column_sums  (column_sums),
        .aligned_sums (aligned_sums)
    );

    result_stage result_stage_i (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .row_valid     (row_valid),
        .aligned_sums  (aligned_sums),
        .shift_amount  (shift_amount),
        .result_valid  (result_valid),
        .result_pixels (result_pixels)
    );

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic                                row_valid,
    input  logic [systolic_pkg::SUMS_W-1:0]     aligned_sums,
    input  logic [systolic_pkg::SHIFT_W-1:0]    shift_amount,
    output logic                                result_valid,
    output logic [systolic_pkg::ROW_W-1:0]      result_pixels
);

    logic [systolic_pkg::PIPE_LATENCY-2:0] tag_pipe;
    logic                                  tag_last;
    logic [systolic_pkg::ROW_W-1:0]        scaled_row;

    //////////////////////////////////////////////////////////////////////
    // valid tag, matched to the data path depth
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_pipe <= '0;
        end else if (en) begin
            tag_pipe <= {tag_pipe[systolic_pkg::PIPE_LATENCY-3:0], row_valid};
        end
    end

    assign tag_last = tag_pipe[systolic_pkg::PIPE_LATENCY-2];

    //////////////////////////////////////////////////////////////////////
    // scale and clamp per lane
    //////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < systolic_pkg::ARRAY_N; j++) begin : g_scale
        logic signed [systolic_pkg::ACC_W-1:0] shifted;
        logic                                  overflow;

        assign shifted =
            $signed(aligned_sums[j*systolic_pkg::ACC_W +: systolic_pkg::ACC_W]) >>> shift_amount;

        // fits only if the top bits are all sign copies
        assign overflow =
            shifted[systolic_pkg::ACC_W-1:systolic_pkg::PIXEL_W-1] !=
            {(systolic_pkg::ACC_W-systolic_pkg::PIXEL_W+1){shifted[systolic_pkg::ACC_W-1]}};

        assign scaled_row[j*systolic_pkg::PIXEL_W +: systolic_pkg::PIXEL_W] =
            !overflow ? shifted[systolic_pkg::PIXEL_W-1:0] :
            shifted[systolic_pkg::ACC_W-1] ? {1'b1, {(systolic_pkg::PIXEL_W-1){1'b0}}} :
                                             {1'b0, {(systolic_pkg::PIXEL_W-1){1'b1}}};
    end

    // one pulse per valid row, output held otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid  <= 1'b0;
            result_pixels <= '0;
        end else begin
            result_valid <= en && tag_last;
            if (en && tag_last) begin
                result_pixels <= scaled_row;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/output_deskew.sv
`timescale 1ns/1ps
`default_nettype none

module output_deskew (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            en,
    input  logic [systolic_pkg::SUMS_W-1:0] column_sums,
    output logic [systolic_pkg::SUMS_W-1:0] aligned_sums
);

    //////////////////////////////////////////////////////////////////////
    // column j gets N-1-j delay stages
    //////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < systolic_pkg::ARRAY_N; j++) begin : g_col
        if (j == systolic_pkg::ARRAY_N - 1) begin : g_pass
            // last column is already the latest
            assign aligned_sums[j*systolic_pkg::ACC_W +: systolic_pkg::ACC_W] =
                column_sums[j*systolic_pkg::ACC_W +: systolic_pkg::ACC_W];
        end else begin : g_delay
            logic [systolic_pkg::ACC_W-1:0] stage [systolic_pkg::ARRAY_N-1-j];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int k = 0; k < systolic_pkg::ARRAY_N - 1 - j; k++) begin
                        stage[k] <= '0;
                    end
                end else if (en) begin
                    stage[0] <= column_sums[j*systolic_pkg::ACC_W +: systolic_pkg::ACC_W];
                    for (int k = 1; k < systolic_pkg::ARRAY_N - 1 - j; k++) begin
                        stage[k] <= stage[k-1];
                    end
                end
            end

            assign aligned_sums[j*systolic_pkg::ACC_W +: systolic_pkg::ACC_W] =
                stage[systolic_pkg::ARRAY_N-2-j];
        end
    end

endmodule

`default_nettype wire

//--- source/pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module pe_array (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic [systolic_pkg::ROW_W-1:0]      skewed_pixels,
    input  logic [systolic_pkg::WEIGHTS_W-1:0]  weights,
    output logic [systolic_pkg::SUMS_W-1:0]     column_sums
);

    // horizontal pixel links, one extra on the right edge
    logic signed [systolic_pkg::PIXEL_W-1:0]
        pixel_link [systolic_pkg::ARRAY_N][systolic_pkg::ARRAY_N+1];

    // vertical partial sum links, one extra at the top
    logic signed [systolic_pkg::ACC_W-1:0]
        sum_link [systolic_pkg::ARRAY_N+1][systolic_pkg::ARRAY_N];

    //////////////////////////////////////////////////////////////////////
    // edges
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < systolic_pkg::ARRAY_N; i++) begin : g_left
        assign pixel_link[i][0] =
            skewed_pixels[i*systolic_pkg::PIXEL_W +: systolic_pkg::PIXEL_W];
    end

    for (genvar j = 0; j < systolic_pkg::ARRAY_N; j++) begin : g_edge
        // top row starts from zero
        assign sum_link[0][j] = '0;
        assign column_sums[j*systolic_pkg::ACC_W +: systolic_pkg::ACC_W] =
            sum_link[systolic_pkg::ARRAY_N][j];
    end

    //////////////////////////////////////////////////////////////////////
    // grid
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < systolic_pkg::ARRAY_N; i++) begin : g_row
        for (genvar j = 0; j < systolic_pkg::ARRAY_N; j++) begin : g_col
            systolic_pe pe_i (
                .clk       (clk),
                .reset     (reset),
                .en        (en),
                .pixel_in  (pixel_link[i][j]),
                .weight    (weights[(i*systolic_pkg::ARRAY_N+j)*systolic_pkg::WEIGHT_W
                                    +: systolic_pkg::WEIGHT_W]),
                .sum_in    (sum_link[i][j]),
                .pixel_out (pixel_link[i][j+1]),
                .sum_out   (sum_link[i+1][j])
            );
        end
    end

endmodule

`default_nettype wire

//--- source/systolic_pe.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_pe (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  en,
    input  logic signed [systolic_pkg::PIXEL_W-1:0]  pixel_in,
    input  logic signed [systolic_pkg::WEIGHT_W-1:0] weight,
    input  logic signed [systolic_pkg::ACC_W-1:0]    sum_in,
    output logic signed [systolic_pkg::PIXEL_W-1:0]  pixel_out,
    output logic signed [systolic_pkg::ACC_W-1:0]    sum_out
);

    // product sign-extended to accumulator width
    logic signed [systolic_pkg::ACC_W-1:0] product;

    assign product = pixel_in * weight;

    // pixel moves right, partial sum moves down
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_out <= '0;
            sum_out   <= '0;
        end else if (en) begin
            pixel_out <= pixel_in;
            sum_out   <= sum_in + product;
        end
    end

endmodule

`default_nettype wire

//--- source/input_skew.sv
`timescale 1ns/1ps
`default_nettype none

module input_skew (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            en,
    input  logic [systolic_pkg::ROW_W-1:0]  row_pixels,
    output logic [systolic_pkg::ROW_W-1:0]  skewed_pixels
);

    //////////////////////////////////////////////////////////////////////
    // lane i gets i delay stages
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < systolic_pkg::ARRAY_N; i++) begin : g_lane
        if (i == 0) begin : g_pass
            // first lane enters the array directly
            assign skewed_pixels[0 +: systolic_pkg::PIXEL_W] =
                row_pixels[0 +: systolic_pkg::PIXEL_W];
        end else begin : g_delay
            logic [systolic_pkg::PIXEL_W-1:0] stage [i];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int k = 0; k < i; k++) begin
                        stage[k] <= '0;
                    end
                end else if (en) begin
                    stage[0] <= row_pixels[i*systolic_pkg::PIXEL_W +: systolic_pkg::PIXEL_W];
                    for (int k = 1; k < i; k++) begin
                        stage[k] <= stage[k-1];
                    end
                end
            end

            assign skewed_pixels[i*systolic_pkg::PIXEL_W +: systolic_pkg::PIXEL_W] =
                stage[i-1];
        end
    end

endmodule

`default_nettype wire

//--- source/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

module weight_bank (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cfg_wr,
    input  systolic_pkg::cfg_reg_t              cfg_sel,
    input  logic [3:0]                          cfg_addr,
    input  logic [15:0]                         cfg_data,
    output logic [systolic_pkg::WEIGHTS_W-1:0]  weights,
    output logic [systolic_pkg::SHIFT_W-1:0]    shift_amount
);

    // w[i][j] lives at entry i*N+j
    logic [systolic_pkg::WEIGHT_W-1:0] weight_regs [systolic_pkg::WEIGHT_CNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < systolic_pkg::WEIGHT_CNT; k++) begin
                weight_regs[k] <= '0;
            end
            shift_amount <= '0;
        end else if (cfg_wr) begin
            case (cfg_sel)
                systolic_pkg::REG_WEIGHT: begin
                    weight_regs[cfg_addr] <= cfg_data;
                end
                systolic_pkg::REG_SHIFT: begin
                    shift_amount <= cfg_data[systolic_pkg::SHIFT_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // flatten, row-major
    for (genvar k = 0; k < systolic_pkg::WEIGHT_CNT; k++) begin : g_flat
        assign weights[k*systolic_pkg::WEIGHT_W +: systolic_pkg::WEIGHT_W] = weight_regs[k];
    end

endmodule

`default_nettype wire

//--- source/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

    //////////////////////////////////////////////////////////////////////
    // array geometry and widths
    //////////////////////////////////////////////////////////////////////

    localparam int ARRAY_N  = 4;
    localparam int PIXEL_W  = 16;
    localparam int WEIGHT_W = 16;

    // four 32-bit products fit with headroom
    localparam int ACC_W    = 36;

    // arithmetic right shift, 0 to 31
    localparam int SHIFT_W  = 5;

    // skew + array + deskew + result register
    localparam int PIPE_LATENCY = 2 * ARRAY_N;

    // flat bus widths
    localparam int ROW_W      = ARRAY_N * PIXEL_W;
    localparam int WEIGHT_CNT = ARRAY_N * ARRAY_N;
    localparam int WEIGHTS_W  = WEIGHT_CNT * WEIGHT_W;
    localparam int SUMS_W     = ARRAY_N * ACC_W;

    //////////////////////////////////////////////////////////////////////
    // configuration register selectors
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        REG_WEIGHT = 1'b0,
        REG_SHIFT  = 1'b1
    } cfg_reg_t;

endpackage

`default_nettype wire
